/* all.f */
hw/viterbiPkg.sv
hw/soqpskBranchMux.sv
hw/soqpskAcs.sv
hw/soqpskAcsBank.sv
hw/soqpskMaxMetric.sv
hw/soqpskTraceback.sv
hw/soqpskViterbi.sv
test/soqpskViterbiTb.sv

/* hw/soqpskAcs.sv */
// Single add-compare-select unit
//   Two candidate metrics, larger one kept, tie keeps candidate 0
//   Multiplicative metric decay and shared normalization step
//   Survivor bit, winning imaginary part and normalization request

module soqpskAcs (
   input  logic                clk,
   input  logic                reset,
   input  logic                symEn,
   input  logic [7:0]          decayFactor,
   input  viterbiPkg::branch_t branch,
   input  viterbiPkg::metric_t ownMet,
   input  viterbiPkg::metric_t partnerMet,
   input  logic                normalize,
   output viterbiPkg::metric_t metric,
   output logic                sel,
   output viterbiPkg::rot_t    winIm,
   output logic                normReq
);

   viterbiPkg::metric_t                   cand0;
   viterbiPkg::metric_t                   cand1;
   viterbiPkg::metric_t                   winner;
   viterbiPkg::metric_t                   decayTerm;
   viterbiPkg::metric_t                   nextMet;
   logic                                  takeOne;
   logic signed [viterbiPkg::metBits+8:0] decayProd;

   always_comb begin
      cand0   = ownMet + branch.in0Re;
      cand1   = partnerMet + branch.in1Re;
      takeOne = cand1 > cand0;
      winner  = takeOne ? cand1 : cand0;
      // winner * decay / 256, never larger in magnitude than winner
      decayProd = winner * $signed({1'b0, decayFactor});
      decayTerm = decayProd[viterbiPkg::metBits+7:8];
      nextMet   = winner - decayTerm;
      if (normalize) begin
         nextMet = nextMet - viterbiPkg::normStep;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         metric <= '0;
         sel    <= 1'b0;
         winIm  <= '0;
      end else if (symEn) begin
         metric <= nextMet;
         sel    <= takeOne;
         winIm  <= takeOne ? branch.in1Im : branch.in0Im;
      end
   end

   assign normReq = metric >= viterbiPkg::normStep;

endmodule

/* hw/soqpskAcsBank.sv */
// ACS bank of the four-state SOQPSK trellis
//   Four ACS units
//   Predecessor metric routing by symbol parity
//   Common normalization and metric range check

module soqpskAcsBank (
   input  logic                                             clk,
   input  logic                                             reset,
   input  logic                                             symEn,
   input  logic [7:0]                                       decayFactor,
   input  viterbiPkg::branchSet_t                           branches,
   output wire viterbiPkg::metric_t [viterbiPkg::numStates-1:0] metrics,
   output wire [viterbiPkg::numStates-1:0]                  sel,
   output wire viterbiPkg::rot_t [viterbiPkg::numStates-1:0]    winIm
);

   // Reaching this would mean the normalization fell behind
   localparam viterbiPkg::metric_t topQuarter =
      viterbiPkg::metric_t'(2 * viterbiPkg::normStep);

   viterbiPkg::metric_t [viterbiPkg::numStates-1:0] partnerMet;
   logic [viterbiPkg::numStates-1:0]                normReq;
   logic                                            normalize;

   // Any unit above the step pulls all four down together
   assign normalize = |normReq;

   for (genvar g = 0; g < viterbiPkg::numStates; g++) begin : g_acs

      // Candidate 1 comes from the partner state of this parity
      assign partnerMet[g] =
         metrics[viterbiPkg::partnerState(2'(g), branches.parity)];

      soqpskAcs u_acs (
         .clk         (clk),
         .reset       (reset),
         .symEn       (symEn),
         .decayFactor (decayFactor),
         .branch      (branches.br[g]),
         .ownMet      (metrics[g]),
         .partnerMet  (partnerMet[g]),
         .normalize   (normalize),
         .metric      (metrics[g]),
         .sel         (sel[g]),
         .winIm       (winIm[g]),
         .normReq     (normReq[g])
      );

      metricRange: assert property (@(posedge clk) disable iff (reset)
         metrics[g] < topQuarter);

   end

endmodule

/* hw/soqpskBranchMux.sv */
// Branch decode for the SOQPSK Viterbi detector
//   Symbol parity register
//   Bank latch with per-state zero and one branch selection
//   Real part truncation to the metric input width

module soqpskBranchMux (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   symEn,
   input  viterbiPkg::mfBank_t    mfBank,
   output viterbiPkg::branchSet_t branches
);

   logic                   parity;
   viterbiPkg::branchSet_t nextSet;
   viterbiPkg::cplx_t      zb;
   viterbiPkg::cplx_t      ob;

   // Even symbol first after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         parity <= 1'b1;
      end else if (symEn) begin
         parity <= ~parity;
      end
   end

   // Pick each state's two sources for the current parity
   always_comb begin
      nextSet.parity = parity;
      for (int s = 0; s < viterbiPkg::numStates; s++) begin
         zb = viterbiPkg::zeroBranch(mfBank, 2'(s));
         ob = viterbiPkg::oneBranch(mfBank, 2'(s), parity);
         // Keep only the top bits of the real parts
         nextSet.br[s].in0Re = zb.re[viterbiPkg::rotBits-1 -: viterbiPkg::mfBits];
         nextSet.br[s].in1Re = ob.re[viterbiPkg::rotBits-1 -: viterbiPkg::mfBits];
         nextSet.br[s].in0Im = zb.im;
         nextSet.br[s].in1Im = ob.im;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         branches <= '0;
      end else if (symEn) begin
         branches <= nextSet;
      end
   end

   // Parity toggling and the ACS timing rely on spaced strobes
   strobeSpacing: assert property (@(posedge clk) disable iff (reset)
      symEn |=> !symEn);

endmodule

/* hw/soqpskMaxMetric.sv */
// Best-state search over the four path metrics
//   Signed four-way maximum, lowest index wins a tie

module soqpskMaxMetric (
   input  viterbiPkg::metric_t [viterbiPkg::numStates-1:0] metrics,
   output logic [1:0]                                      bestState
);

   viterbiPkg::metric_t bestMet;

   always_comb begin
      bestMet   = metrics[0];
      bestState = 2'd0;
      // Strict compare keeps the earlier index on equal metrics
      for (int i = 1; i < viterbiPkg::numStates; i++) begin
         if (metrics[i] > bestMet) begin
            bestMet   = metrics[i];
            bestState = 2'(i);
         end
      end
   end

endmodule

/* hw/soqpskTraceback.sv */
// Survivor traceback and output registers
//   Shift memory of survivor words with their parity
//   Combinational trace from the best state back to the oldest entry
//   Index, hard decision and phase error registers

module soqpskTraceback #(
   parameter int traceDepth = 16
) (
   input  logic                                          clk,
   input  logic                                          reset,
   input  logic                                          symEn,
   input  logic [viterbiPkg::numStates-1:0]              sel,
   input  viterbiPkg::rot_t [viterbiPkg::numStates-1:0]  winIm,
   input  logic                                          parity,
   input  logic [1:0]                                    bestState,
   output logic [1:0]                                    index,
   output logic                                          decision,
   output viterbiPkg::rot_t                              phaseError
);

   typedef struct packed {
      logic [viterbiPkg::numStates-1:0] sel;
      logic                             parity;
   } survWord_t;

   survWord_t  mem [traceDepth];
   survWord_t  pushWord;
   logic [1:0] traceState;
   logic       tracedBit;
   logic       primed;

   // ------------------------------------------------------------------------
   // Trace back, newest word first
   // ------------------------------------------------------------------------
   always_comb begin
      // Parity input is one symbol ahead of the survivor word
      pushWord.sel    = sel;
      pushWord.parity = ~parity;
      traceState = bestState;
      if (pushWord.sel[traceState]) begin
         traceState = viterbiPkg::partnerState(traceState, pushWord.parity);
      end
      for (int i = 0; i < traceDepth - 1; i++) begin
         if (mem[i].sel[traceState]) begin
            traceState = viterbiPkg::partnerState(traceState, mem[i].parity);
         end
      end
      tracedBit = ~mem[traceDepth-1].sel[traceState];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         primed     <= 1'b0;
         index      <= 2'd0;
         decision   <= 1'b0;
         phaseError <= '0;
         for (int i = 0; i < traceDepth; i++) begin
            mem[i] <= '0;
         end
      end else if (symEn) begin
         primed <= 1'b1;
         mem[0] <= pushWord;
         for (int i = 1; i < traceDepth; i++) begin
            mem[i] <= mem[i-1];
         end
         // No ACS result exists before the first strobe
         if (primed) begin
            index      <= bestState;
            decision   <= tracedBit;
            phaseError <= winIm[bestState];
         end
      end
   end

   bestKnown: assert property (@(posedge clk) disable iff (reset)
      symEn |-> !$isunknown(bestState));

endmodule

/* hw/soqpskViterbi.sv */
// Top level of the SOQPSK four-state Viterbi detector
//   Branch decode, ACS bank, best-state search and traceback
//   Hard bit, best state and phase error once per symbol strobe

module soqpskViterbi #(
   parameter int traceDepth = 16
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                symEn,
   input  logic [7:0]          decayFactor,
   input  viterbiPkg::mfBank_t mfBank,
   output logic [1:0]          index,
   output logic                decision,
   output viterbiPkg::rot_t    phaseError
);

   viterbiPkg::branchSet_t                          branches;
   viterbiPkg::metric_t [viterbiPkg::numStates-1:0] metrics;
   logic [viterbiPkg::numStates-1:0]                sel;
   viterbiPkg::rot_t [viterbiPkg::numStates-1:0]    winIm;
   logic [1:0]                                      bestState;

   // ------------------------------------------------------------------------
   // Decode
   // ------------------------------------------------------------------------
   soqpskBranchMux u_branchMux (
      .clk      (clk),
      .reset    (reset),
      .symEn    (symEn),
      .mfBank   (mfBank),
      .branches (branches)
   );

   // ------------------------------------------------------------------------
   // Execute
   // ------------------------------------------------------------------------
   soqpskAcsBank u_acsBank (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .decayFactor (decayFactor),
      .branches    (branches),
      .metrics     (metrics),
      .sel         (sel),
      .winIm       (winIm)
   );

   // ------------------------------------------------------------------------
   // Result
   // ------------------------------------------------------------------------
   soqpskMaxMetric u_maxMetric (
      .metrics   (metrics),
      .bestState (bestState)
   );

   soqpskTraceback #(
      .traceDepth (traceDepth)
   ) u_traceback (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .sel        (sel),
      .winIm      (winIm),
      .parity     (branches.parity),
      .bestState  (bestState),
      .index      (index),
      .decision   (decision),
      .phaseError (phaseError)
   );

endmodule

/* hw/viterbiPkg.sv */
// Shared definitions for the SOQPSK four-state Viterbi detector
//   Width constants and scalar types
//   Matched-filter sample, bank and branch structs
//   Trellis routing functions for predecessors and branch sources

package viterbiPkg;

   parameter int rotBits   = 10;
   parameter int mfBits    = 8;
   parameter int metBits   = mfBits + 4;
   parameter int numStates = 4;

   typedef logic signed [rotBits-1:0] rot_t;
   typedef logic signed [mfBits-1:0]  mf_t;
   typedef logic signed [metBits-1:0] metric_t;

   // Quarter of the metric range, removed from all metrics together
   parameter metric_t normStep = metric_t'(2 ** (metBits - 3));

   typedef struct packed {
      rot_t re;
      rot_t im;
   } cplx_t;

   // Zero, plus and minus rotation outputs of each state
   typedef struct packed {
      cplx_t [numStates-1:0] zr;
      cplx_t [numStates-1:0] pr;
      cplx_t [numStates-1:0] mr;
   } mfBank_t;

   typedef struct packed {
      mf_t  in0Re;
      mf_t  in1Re;
      rot_t in0Im;
      rot_t in1Im;
   } branch_t;

   typedef struct packed {
      branch_t [numStates-1:0] br;
      logic                    parity;
   } branchSet_t;

   // ------------------------------------------------------------------------
   // Trellis routing, parity 1 is the even symbol
   // ------------------------------------------------------------------------

   // Predecessor behind candidate 1
   function automatic logic [1:0] partnerState(input logic [1:0] state, input logic parity);
      return parity ? (state ^ 2'd2) : (state ^ 2'd1);
   endfunction

   function automatic cplx_t zeroBranch(input mfBank_t bank, input logic [1:0] state);
      case (state)
         2'd0:    return bank.zr[3];
         2'd1:    return bank.zr[2];
         2'd2:    return bank.zr[0];
         default: return bank.zr[1];
      endcase
   endfunction

   function automatic cplx_t oneBranch(input mfBank_t bank, input logic [1:0] state,
                                       input logic parity);
      case (state)
         2'd0:    return parity ? bank.pr[2] : bank.mr[0];
         2'd1:    return parity ? bank.mr[3] : bank.pr[1];
         2'd2:    return parity ? bank.mr[1] : bank.pr[3];
         default: return parity ? bank.pr[0] : bank.mr[2];
      endcase
   endfunction

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build and run the SOQPSK Viterbi testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f all.f --top-module soqpskViterbiTb -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
   exit 0
else
   exit 1
fi

/* test/soqpskViterbiTb.sv */
// Testbench for the SOQPSK four-state Viterbi detector
//   Clock, reset and seeded random symbol stimulus
//   Behavioral trellis model with decay, normalization and traceback
//   Value check task, hold checks between strobes and cycle timeout

module soqpskViterbiTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int traceDepth    = 16;
   localparam int resetCycles   = 10;
   localparam int resetSymbols  = 2;
   localparam int randomSymbols = 400;
   localparam int normSymbols   = 400;
   localparam int decaySymbols  = 200;
   localparam int maxGap        = 8;
   localparam int normStepModel = 512;
   localparam int totalSymbols  =
      resetSymbols + randomSymbols + normSymbols + decaySymbols;
   localparam int cycleLimit    = totalSymbols * maxGap + resetCycles + 100;

   logic                clk;
   logic                reset;
   logic                symEn;
   logic [7:0]          decayFactor;
   viterbiPkg::mfBank_t mfBank;
   logic [1:0]          index;
   logic                decision;
   viterbiPkg::rot_t    phaseError;

   int cycleCount = 0;

   // Driven bank with zero rotation in entries 0 to 3, plus in 4 to 7 and minus in 8 to 11
   int bankRe [12];
   int bankIm [12];

   // Model registers
   int         parity;
   int         brIn0Re [4];
   int         brIn1Re [4];
   int         brIn0Im [4];
   int         brIn1Im [4];
   int         brParity;
   int         met [4];
   logic [3:0] survSel;
   int         survPar;
   int         winIm [4];
   logic [3:0] memSel [traceDepth];
   int         memPar [traceDepth];
   int         primed;
   int         expIndex;
   int         expDecision;
   int         expPhase;

   soqpskViterbi #(
      .traceDepth (traceDepth)
   ) i_dut (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .decayFactor (decayFactor),
      .mfBank      (mfBank),
      .index       (index),
      .decision    (decision),
      .phaseError  (phaseError)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: the run hung after %0d cycles", cycleCount);
         $display("TEST FAILED");
         $fatal(1, "Simulation stopped by the cycle limit");
      end
   end

   // ------------------------------------------------------------------------
   // Trellis tables
   // ------------------------------------------------------------------------

   // Predecessor feeding candidate 1 where parity 1 means even
   function automatic int predecessor(input int state, input int par);
      if (par != 0) begin
         case (state)
            0:       return 2;
            1:       return 3;
            2:       return 0;
            default: return 1;
         endcase
      end
      case (state)
         0:       return 1;
         1:       return 0;
         2:       return 3;
         default: return 2;
      endcase
   endfunction

   function automatic int zeroSource(input int state);
      case (state)
         0:       return 3;
         1:       return 2;
         2:       return 0;
         default: return 1;
      endcase
   endfunction

   // Bank entry of the one-branch with plus at 4+i and minus at 8+i
   function automatic int oneSource(input int state, input int par);
      if (par != 0) begin
         case (state)
            0:       return 6;
            1:       return 11;
            2:       return 9;
            default: return 4;
         endcase
      end
      case (state)
         0:       return 8;
         1:       return 5;
         2:       return 7;
         default: return 10;
      endcase
   endfunction

   function automatic int wrapMetric(input int value);
      int low;
      low = ((value % 4096) + 4096) % 4096;
      return (low >= 2048) ? low - 4096 : low;
   endfunction

   function automatic int truncReal(input int re);
      return re >>> 2;
   endfunction

   // ------------------------------------------------------------------------
   // Model
   // ------------------------------------------------------------------------
   task automatic resetModel();
      parity   = 1;
      brParity = 0;
      survSel  = 4'b0;
      survPar  = 1;
      primed   = 0;
      expIndex    = 0;
      expDecision = 0;
      expPhase    = 0;
      for (int s = 0; s < 4; s++) begin
         brIn0Re[s] = 0;
         brIn1Re[s] = 0;
         brIn0Im[s] = 0;
         brIn1Im[s] = 0;
         met[s]     = 0;
         winIm[s]   = 0;
      end
      for (int i = 0; i < traceDepth; i++) begin
         memSel[i] = 4'b0;
         memPar[i] = 0;
      end
   endtask

   // One strobe edge where every stage reads the values from before it
   task automatic modelStrobe();
      int         best;
      int         st;
      int         cand0;
      int         cand1;
      int         winner;
      int         nextMet;
      int         normalize;
      int         src;
      int         newMet [4];
      int         newWin [4];
      logic [3:0] newSel;
      best = 0;
      for (int s = 1; s < 4; s++) begin
         if (met[s] > met[best]) begin
            best = s;
         end
      end
      // Traceback from the best state through the word being pushed
      st = best;
      if (survSel[st]) begin
         st = predecessor(st, survPar);
      end
      for (int i = 0; i < traceDepth - 1; i++) begin
         if (memSel[i][st]) begin
            st = predecessor(st, memPar[i]);
         end
      end
      if (primed != 0) begin
         expIndex    = best;
         expDecision = memSel[traceDepth-1][st] ? 0 : 1;
         expPhase    = winIm[best];
      end
      for (int i = traceDepth - 1; i > 0; i--) begin
         memSel[i] = memSel[i-1];
         memPar[i] = memPar[i-1];
      end
      memSel[0] = survSel;
      memPar[0] = survPar;
      primed    = 1;
      // ACS with decay and shared normalization
      normalize = 0;
      for (int s = 0; s < 4; s++) begin
         if (met[s] >= normStepModel) begin
            normalize = 1;
         end
      end
      for (int s = 0; s < 4; s++) begin
         cand0 = wrapMetric(met[s] + brIn0Re[s]);
         cand1 = wrapMetric(met[predecessor(s, brParity)] + brIn1Re[s]);
         if (cand1 > cand0) begin
            winner    = cand1;
            newSel[s] = 1'b1;
            newWin[s] = brIn1Im[s];
         end else begin
            winner    = cand0;
            newSel[s] = 1'b0;
            newWin[s] = brIn0Im[s];
         end
         nextMet = winner - ((winner * int'(decayFactor)) >>> 8);
         if (normalize != 0) begin
            nextMet = nextMet - normStepModel;
         end
         newMet[s] = wrapMetric(nextMet);
      end
      met     = newMet;
      winIm   = newWin;
      survSel = newSel;
      survPar = brParity;
      // Branch latch for the new bank
      for (int s = 0; s < 4; s++) begin
         src = zeroSource(s);
         brIn0Re[s] = truncReal(bankRe[src]);
         brIn0Im[s] = bankIm[src];
         src = oneSource(s, parity);
         brIn1Re[s] = truncReal(bankRe[src]);
         brIn1Im[s] = bankIm[src];
      end
      brParity = parity;
      parity   = 1 - parity;
   endtask

   // ------------------------------------------------------------------------
   // Stimulus and checks
   // ------------------------------------------------------------------------
   task automatic checkValue(input string testName, input int expected, input int actual);
      if (expected != actual) begin
         $display("Fail %s expected %0d actual %0d", testName, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "Mismatch in %s", testName);
      end
   endtask

   // Positive bias keeps the real parts at or above zero
   task automatic fillBank(input bit biased);
      for (int k = 0; k < 12; k++) begin
         if (biased) begin
            bankRe[k] = int'($urandom_range(511, 0));
         end else begin
            bankRe[k] = int'($urandom_range(1023, 0)) - 512;
         end
         bankIm[k] = int'($urandom_range(1023, 0)) - 512;
      end
      for (int i = 0; i < 4; i++) begin
         mfBank.zr[i].re = viterbiPkg::rot_t'(bankRe[i]);
         mfBank.zr[i].im = viterbiPkg::rot_t'(bankIm[i]);
         mfBank.pr[i].re = viterbiPkg::rot_t'(bankRe[4+i]);
         mfBank.pr[i].im = viterbiPkg::rot_t'(bankIm[4+i]);
         mfBank.mr[i].re = viterbiPkg::rot_t'(bankRe[8+i]);
         mfBank.mr[i].im = viterbiPkg::rot_t'(bankIm[8+i]);
      end
   endtask

   // Called 2 ns after a rising edge and returns at the same offset
   task automatic sendSymbol(input string testName, input bit biased, input int decay);
      int gap;
      gap = int'($urandom_range(maxGap, 2));
      fillBank(biased);
      decayFactor = 8'(decay);
      symEn       = 1'b1;
      modelStrobe();
      @(posedge clk);
      #2;
      symEn = 1'b0;
      checkValue({testName, " index"}, expIndex, int'(index));
      checkValue({testName, " decision"}, expDecision, int'(decision));
      checkValue({testName, " phaseError"}, expPhase, int'(phaseError));
      // Model outputs stay fixed until the next strobe
      for (int c = 1; c < gap; c++) begin
         @(posedge clk);
         #2;
         checkValue({testName, " hold index"}, expIndex, int'(index));
         checkValue({testName, " hold decision"}, expDecision, int'(decision));
         checkValue({testName, " hold phaseError"}, expPhase, int'(phaseError));
      end
   endtask

   initial begin
      void'($urandom(33195));
      reset       = 1'b1;
      symEn       = 1'b0;
      decayFactor = 8'd0;
      mfBank      = '0;
      resetModel();
      repeat (resetCycles) @(posedge clk);
      #2;
      reset = 1'b0;
      @(posedge clk);
      #2;
      checkValue("reset index", 0, int'(index));
      checkValue("reset decision", 0, int'(decision));
      checkValue("reset phaseError", 0, int'(phaseError));
      // First strobe leaves the outputs at zero
      sendSymbol("first strobe", 1'b0, 128);
      checkValue("first strobe zero phaseError", 0, int'(phaseError));
      sendSymbol("second strobe", 1'b0, 128);

      for (int n = 0; n < randomSymbols; n++) begin
         sendSymbol("random decoding", 1'b0, int'($urandom_range(255, 1)));
      end
      for (int n = 0; n < normSymbols; n++) begin
         sendSymbol("normalization", 1'b1, 0);
      end
      for (int n = 0; n < decaySymbols; n++) begin
         sendSymbol("strong decay", 1'b0, 255);
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule
